/* Makefile */
TOP := tbMiniDatapath

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f miniDatapath.f --top-module $(TOP) -o $(TOP)

# the run fails unless the pass message shows up in the output
run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -Wall \
		-f miniDatapath.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* miniDatapath.f */
source/miniDatapathPkg.sv
source/ctrlIf.sv
source/instrDecode.sv
source/regFile.sv
source/aluUnit.sv
source/miniDatapath.sv
tests/miniDatapath_checker.sv
tests/tbMiniDatapath.sv

/* source/aluUnit.sv */
// result is combinational from the operands; carry and zero flags update one edge later on flagWrite
`timescale 1ns/1ps

module aluUnit (
	input  logic                                  clk,
	input  logic                                  rstN,
	ctrlIf.alu                                    ctrl,
	input  logic [miniDatapathPkg::dataWidth-1:0] operandA,
	input  logic [miniDatapathPkg::dataWidth-1:0] operandB,
	output logic [miniDatapathPkg::dataWidth-1:0] aluBus,
	output logic                                  carryFlag,
	output logic                                  zeroFlag
);
	import miniDatapathPkg::*;

	logic [dataWidth:0]   wideSum;  // extra bit holds carry or borrow
	logic [dataWidth:0]   wideDiff;
	logic [dataWidth:0]   wideAdc;
	logic [dataWidth-1:0] result;
	logic                 carryNext;

	assign wideSum  = {1'b0, operandA} + {1'b0, operandB};
	assign wideDiff = {1'b0, operandA} - {1'b0, operandB}; // top bit set when operandA < operandB
	assign wideAdc  = wideSum + {{dataWidth{1'b0}}, carryFlag};

	// ----------------------------------------------------------------------
	// result and next carry
	// ----------------------------------------------------------------------
	always_comb begin
		result    = '0;
		carryNext = carryFlag;
		case (ctrl.aluOp)
			opAdd: {carryNext, result} = wideSum;
			opSub: {carryNext, result} = wideDiff;
			opAdc: {carryNext, result} = wideAdc;
			opAnd: begin
				result    = operandA & operandB;
				carryNext = 1'b0;
			end
			opOr: begin
				result    = operandA | operandB;
				carryNext = 1'b0;
			end
			opXor: begin
				result    = operandA ^ operandB;
				carryNext = 1'b0;
			end
			opShl: {carryNext, result} = {operandA, 1'b0};
			opShr: {result, carryNext} = {1'b0, operandA};
			opMov: result = operandA;
			opLdi: result = {{(dataWidth-immWidth){1'b0}}, ctrl.imm8};
			opLui: result = {ctrl.imm8, operandA[immWidth-1:0]}; // operandA is rd here
			default: result = '0;
		endcase
	end

	assign aluBus = result;

	// ----------------------------------------------------------------------
	// flags
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rstN) begin
			carryFlag <= 1'b0;
			zeroFlag  <= 1'b0;
		end else if (ctrl.flagWrite) begin
			carryFlag <= carryNext;
			zeroFlag  <= (result == '0);
		end
	end

endmodule

/* source/ctrlIf.sv */
// decoded control for one instruction; only meaningful in the cycle it is decoded, no storage
`timescale 1ns/1ps

interface ctrlIf;
	import miniDatapathPkg::*;

	logic [regCount-1:0]     regEnable; // one-hot, all zero when nothing is written
	logic [regAddrWidth-1:0] srcA;
	logic [regAddrWidth-1:0] srcB;
	aluOpT                   aluOp;
	logic [immWidth-1:0]     imm8;
	logic                    flagWrite;

	modport decoder (
		output regEnable, srcA, srcB, aluOp, imm8, flagWrite
	);

	modport regs (
		input regEnable, srcA, srcB
	);

	modport alu (
		input aluOp, imm8, flagWrite
	);

endinterface

/* source/instrDecode.sv */
// purely combinational; a low instrValid or an unused opcode never produces a write
`timescale 1ns/1ps

module instrDecode (
	input  logic [miniDatapathPkg::dataWidth-1:0] instr,
	input  logic                                  instrValid,
	ctrlIf.decoder                                ctrl
);
	import miniDatapathPkg::*;

	logic [opcodeWidth-1:0]  opcode;
	logic [regAddrWidth-1:0] rd;
	logic [regAddrWidth-1:0] rs;
	logic [regAddrWidth-1:0] rt;
	aluOpT                   decodedOp;
	logic                    writesReg;
	logic                    setsFlags;

	assign opcode = instr[opcodeLsb +: opcodeWidth];
	assign rd     = instr[rdLsb +: regAddrWidth];
	assign rs     = instr[rsLsb +: regAddrWidth];
	assign rt     = instr[rtLsb +: regAddrWidth];

	// ----------------------------------------------------------------------
	// opcode to operation
	// ----------------------------------------------------------------------
	always_comb begin
		case (opcode)
			opcNop:  decodedOp = opNop;
			opcAdd:  decodedOp = opAdd;
			opcSub:  decodedOp = opSub;
			opcAnd:  decodedOp = opAnd;
			opcOr:   decodedOp = opOr;
			opcXor:  decodedOp = opXor;
			opcShl:  decodedOp = opShl;
			opcShr:  decodedOp = opShr;
			opcMov:  decodedOp = opMov;
			opcLdi:  decodedOp = opLdi;
			opcLui:  decodedOp = opLui;
			opcAdc:  decodedOp = opAdc;
			default: decodedOp = opNop; // 12 to 15 behave as NOP
		endcase
	end

	// every operation except NOP writes rd
	assign writesReg = (decodedOp != opNop);

	// MOV, LDI and LUI leave the flags alone
	always_comb begin
		case (decodedOp)
			opAdd, opSub, opAdc, opAnd, opOr, opXor, opShl, opShr: setsFlags = 1'b1;
			default: setsFlags = 1'b0;
		endcase
	end

	// ----------------------------------------------------------------------
	// control outputs
	// ----------------------------------------------------------------------
	always_comb begin
		ctrl.aluOp     = opNop;
		ctrl.regEnable = '0;
		ctrl.flagWrite = 1'b0;
		if (instrValid) begin
			ctrl.aluOp     = decodedOp;
			ctrl.flagWrite = setsFlags;
			if (writesReg) ctrl.regEnable = {{(regCount-1){1'b0}}, 1'b1} << rd;
		end
	end

	// LUI reads rd so the ALU can keep its low byte
	assign ctrl.srcA = (decodedOp == opLui) ? rd : rs;
	assign ctrl.srcB = rt;
	assign ctrl.imm8 = instr[immLsb +: immWidth];

endmodule

/* source/miniDatapath.sv */
// one instruction per cycle, no back-pressure; results and flags appear one edge after a valid instruction
`timescale 1ns/1ps

module miniDatapath (
	input  logic                                     clk,
	input  logic                                     rstN,
	input  logic [miniDatapathPkg::dataWidth-1:0]    instr,
	input  logic                                     instrValid,
	input  logic [miniDatapathPkg::regAddrWidth-1:0] dbgAddr,
	output logic [miniDatapathPkg::dataWidth-1:0]    dbgData,
	output logic                                     carryFlag,
	output logic                                     zeroFlag
);
	import miniDatapathPkg::*;

	// ----------------------------------------------------------------------
	// internal wiring
	// ----------------------------------------------------------------------
	logic [dataWidth-1:0] operandA;
	logic [dataWidth-1:0] operandB;
	logic [dataWidth-1:0] aluBus; // shared result bus, written into rd

	ctrlIf ctrl ();

	// ----------------------------------------------------------------------
	// decoder
	// ----------------------------------------------------------------------
	// the only place where instrValid is looked at
	instrDecode i_instrDecode (
		.instr      (instr),
		.instrValid (instrValid),
		.ctrl       (ctrl.decoder)
	);

	// ----------------------------------------------------------------------
	// register file
	// ----------------------------------------------------------------------
	regFile i_regFile (
		.clk      (clk),
		.rstN     (rstN),
		.ctrl     (ctrl.regs),
		.aluBus   (aluBus),
		.operandA (operandA),
		.operandB (operandB),
		.dbgAddr  (dbgAddr),
		.dbgData  (dbgData)
	);

	// ----------------------------------------------------------------------
	// ALU and flags
	// ----------------------------------------------------------------------
	aluUnit i_aluUnit (
		.clk       (clk),
		.rstN      (rstN),
		.ctrl      (ctrl.alu),
		.operandA  (operandA),
		.operandB  (operandB),
		.aluBus    (aluBus),
		.carryFlag (carryFlag), // also feeds ADC inside the ALU
		.zeroFlag  (zeroFlag)
	);

endmodule

/* source/miniDatapathPkg.sv */
// assumes a 16-bit instruction word with a 4-bit opcode in the top nibble; codes 12 to 15 are unused
package miniDatapathPkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------
	localparam int dataWidth    = 16; // register and aluBus width
	localparam int regCount     = 16;
	localparam int regAddrWidth = 4;
	localparam int opcodeWidth  = 4;
	localparam int immWidth     = 8;

	// lowest bit of each field in the instruction word
	localparam int opcodeLsb = 12;
	localparam int rdLsb     = 8;
	localparam int rsLsb     = 4;
	localparam int rtLsb     = 0;
	localparam int immLsb    = 0; // imm8 overlaps rs and rt

	// ----------------------------------------------------------------------
	// opcode values
	// ----------------------------------------------------------------------
	localparam logic [opcodeWidth-1:0] opcNop = 4'd0;
	localparam logic [opcodeWidth-1:0] opcAdd = 4'd1;
	localparam logic [opcodeWidth-1:0] opcSub = 4'd2;
	localparam logic [opcodeWidth-1:0] opcAnd = 4'd3;
	localparam logic [opcodeWidth-1:0] opcOr  = 4'd4;
	localparam logic [opcodeWidth-1:0] opcXor = 4'd5;
	localparam logic [opcodeWidth-1:0] opcShl = 4'd6;
	localparam logic [opcodeWidth-1:0] opcShr = 4'd7;
	localparam logic [opcodeWidth-1:0] opcMov = 4'd8;
	localparam logic [opcodeWidth-1:0] opcLdi = 4'd9;
	localparam logic [opcodeWidth-1:0] opcLui = 4'd10;
	localparam logic [opcodeWidth-1:0] opcAdc = 4'd11;

	// decoded operation, as seen by the ALU
	typedef enum logic [3:0] {
		opNop,
		opAdd,
		opSub,
		opAnd,
		opOr,
		opXor,
		opShl,
		opShr,
		opMov,
		opLdi,
		opLui,
		opAdc
	} aluOpT;

endpackage

/* source/regFile.sv */
// sixteen registers, all writable and cleared by reset; read ports are combinational (write-first not provided)
`timescale 1ns/1ps

module regFile (
	input  logic                                     clk,
	input  logic                                     rstN,
	ctrlIf.regs                                      ctrl,
	input  logic [miniDatapathPkg::dataWidth-1:0]    aluBus,
	output logic [miniDatapathPkg::dataWidth-1:0]    operandA,
	output logic [miniDatapathPkg::dataWidth-1:0]    operandB,
	input  logic [miniDatapathPkg::regAddrWidth-1:0] dbgAddr,
	output logic [miniDatapathPkg::dataWidth-1:0]    dbgData
);
	import miniDatapathPkg::*;

	logic [dataWidth-1:0] regs [regCount];

	// ----------------------------------------------------------------------
	// write side
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < regCount; i++) begin
				if (ctrl.regEnable[i]) regs[i] <= aluBus; // at most one bit is set
			end
		end
	end

	// ----------------------------------------------------------------------
	// read side
	// ----------------------------------------------------------------------
	// operands see the values left by the previous edge
	assign operandA = regs[ctrl.srcA];
	assign operandB = regs[ctrl.srcB];

	assign dbgData = regs[dbgAddr]; // debug view, no effect on the datapath

endmodule

/* tests/miniDatapath_checker.sv */
// bound into miniDatapath; reaches the register array by hierarchy and needs reset held for one edge or more
`timescale 1ns/1ps

module miniDatapath_checker (
	input logic                                  clk,
	input logic                                  rstN,
	input logic                                  instrValid,
	input logic [miniDatapathPkg::regCount-1:0]  regEnable,
	input logic                                  flagWrite,
	input logic                                  carryFlag,
	input logic                                  zeroFlag,
	input logic [miniDatapathPkg::dataWidth-1:0] regs [miniDatapathPkg::regCount]
);
	import miniDatapathPkg::*;

	logic allZero;

	always_comb begin
		allZero = 1'b1;
		for (int i = 0; i < regCount; i++) begin
			if (regs[i] != '0) allZero = 1'b0;
		end
	end

	// ----------------------------------------------------------------------
	// properties
	// ----------------------------------------------------------------------
	aOneHot: assert property (@(posedge clk) $onehot0(regEnable))
		else $error("regEnable has more than one bit set");

	aNoWriteIdle: assert property (@(posedge clk) disable iff (!rstN)
		!instrValid |-> regEnable == '0)
		else $error("register write while instrValid is low");

	// flags sampled one edge later must match the ones before
	aFlagsHold: assert property (@(posedge clk) disable iff (!rstN)
		!flagWrite |=> $stable(carryFlag) && $stable(zeroFlag))
		else $error("flags changed without flagWrite");

	aResetClear: assert property (@(posedge clk)
		$rose(rstN) |-> allZero && !carryFlag && !zeroFlag)
		else $error("registers or flags not cleared by reset");

endmodule

bind miniDatapath miniDatapath_checker i_checker (
	.clk        (clk),
	.rstN       (rstN),
	.instrValid (instrValid),
	.regEnable  (ctrl.regEnable),
	.flagWrite  (ctrl.flagWrite),
	.carryFlag  (carryFlag),
	.zeroFlag   (zeroFlag),
	.regs       (i_regFile.regs)
);

/* tests/tbMiniDatapath.sv */
// needs a running clock; every edge wait gives up after 50 ns, debug reads take 1 ns each
`timescale 1ns/1ps

module tbMiniDatapath;
	import miniDatapathPkg::*;

	logic                    clk;
	logic                    rstN;
	logic [dataWidth-1:0]    instr;
	logic                    instrValid;
	logic [regAddrWidth-1:0] dbgAddr;
	logic [dataWidth-1:0]    dbgData;
	logic                    carryFlag;
	logic                    zeroFlag;

	logic [dataWidth-1:0] model [regCount]; // reference register file
	logic                 modelCarry;
	logic                 modelZero;

	logic [31:0] lfsrState;
	int          edgeCount = 0;
	realtime     lastEdge;
	int          checkCount;
	int          errorCount;
	int          testStartErrors;
	string       testName;

	miniDatapath i_miniDatapath (
		.clk        (clk),
		.rstN       (rstN),
		.instr      (instr),
		.instrValid (instrValid),
		.dbgAddr    (dbgAddr),
		.dbgData    (dbgData),
		.carryFlag  (carryFlag),
		.zeroFlag   (zeroFlag)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		edgeCount++;
		lastEdge = $realtime;
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	// returns 1 ns after the next rising edge, whatever the poll phase was
	task automatic waitEdge();
		int startCount;
		int steps;
		startCount = edgeCount;
		steps      = 0;
		while (edgeCount == startCount && steps < 100) begin
			#0.5;
			steps++;
		end
		if (edgeCount == startCount) begin
			$display("timeout: no rising clock edge within 50 ns in test %s", testName);
			$display("*** TEST FAILED ***");
			$finish;
		end else begin
			#(lastEdge + 1.0 - $realtime);
		end
	endtask

	function automatic logic [31:0] randBits(input int count);
		logic [31:0] value;
		logic        feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			value     = {value[30:0], feedback};
		end
		return value;
	endfunction

	task automatic checkEq(input string what, input logic [15:0] expected,
			input logic [15:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH %s %s: expected %h, actual %h", testName, what, expected, actual);
		end
	endtask

	function automatic logic [15:0] regOp(input logic [3:0] opc, input logic [3:0] rd,
			input logic [3:0] rs, input logic [3:0] rt);
		return {opc, rd, rs, rt};
	endfunction

	function automatic logic [15:0] immOp(input logic [3:0] opc, input logic [3:0] rd,
			input logic [7:0] imm);
		return {opc, rd, imm};
	endfunction

	// instruction semantics and flag rules, applied when an instruction is issued
	function automatic void applyModel(input logic [15:0] word);
		logic [3:0]  rd;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic [16:0] wide;
		logic        carry;
		logic        writes;
		logic        flags;
		rd     = word[11:8];
		a      = model[word[7:4]];
		b      = model[word[3:0]];
		res    = '0;
		wide   = '0;
		carry  = modelCarry;
		writes = 1'b1;
		flags  = 1'b1;
		case (word[15:12])
			opcAdd: begin
				wide  = {1'b0, a} + {1'b0, b};
				res   = wide[15:0];
				carry = wide[16];
			end
			opcSub: begin
				res   = a - b;
				carry = (a < b); // borrow
			end
			opcAnd: {carry, res} = {1'b0, a & b};
			opcOr:  {carry, res} = {1'b0, a | b};
			opcXor: {carry, res} = {1'b0, a ^ b};
			opcShl: {carry, res} = {a[15], a[14:0], 1'b0};
			opcShr: {carry, res} = {a[0], 1'b0, a[15:1]};
			opcAdc: begin
				wide  = {1'b0, a} + {1'b0, b} + {16'b0, modelCarry};
				res   = wide[15:0];
				carry = wide[16];
			end
			opcMov: {flags, res} = {1'b0, a};
			opcLdi: {flags, res} = {1'b0, 8'h00, word[7:0]};
			opcLui: {flags, res} = {1'b0, word[7:0], model[rd][7:0]};
			default: {writes, flags} = 2'b00; // NOP and unused codes
		endcase
		if (writes) model[rd] = res;
		if (flags) begin
			modelCarry = carry;
			modelZero  = (res == '0);
		end
	endfunction

	task automatic issue(input logic [15:0] word);
		instr      = word;
		instrValid = 1'b1;
		applyModel(word);
		waitEdge();
		instrValid = 1'b0;
	endtask

	task automatic loadReg(input logic [3:0] rd, input logic [15:0] value);
		issue(immOp(opcLdi, rd, value[7:0]));
		issue(immOp(opcLui, rd, value[15:8]));
	endtask

	task automatic checkFlags();
		checkEq("carry", {15'b0, modelCarry}, {15'b0, carryFlag});
		checkEq("zero", {15'b0, modelZero}, {15'b0, zeroFlag});
	endtask

	task automatic readReg(input logic [3:0] idx);
		dbgAddr = idx;
		#1;
		checkEq($sformatf("r%0d", idx), model[idx], dbgData);
	endtask

	// reads every register and both flags, then lines up with the clock again
	task automatic readAll();
		for (int i = 0; i < regCount; i++) readReg(4'(i));
		checkFlags();
		waitEdge();
	endtask

	task automatic startTest(input string name);
		testName        = name;
		testStartErrors = errorCount;
	endtask

	task automatic endTest();
		$display("test %s finished with %0d errors", testName, errorCount - testStartErrors);
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic testReset();
		startTest("reset");
		readAll();
		endTest();
	endtask

	task automatic testStoreRetrieve();
		logic [15:0] value;
		startTest("storeRetrieve");
		for (int r = 0; r < regCount; r++) begin
			value = 16'(randBits(16));
			loadReg(4'(r), value);
			readReg(4'(r));
			checkEq($sformatf("r%0d direct", r), value, dbgData);
			waitEdge();
		end
		endTest();
	endtask

	task automatic testManyStores();
		startTest("manyStores");
		for (int r = 0; r < regCount; r++) issue(immOp(opcLdi, 4'(r), 8'(r)));
		readAll();
		for (int k = 0; k < regCount; k++) issue(immOp(opcLdi, 4'(15 - k), 8'(k))); // r15 first
		readAll();
		endTest();
	endtask

	task automatic testRandomAlu();
		logic [3:0]  opc;
		logic [3:0]  prevRd;
		logic [15:0] word;
		startTest("randomAlu");
		prevRd = '0;
		for (int r = 0; r < regCount; r++) loadReg(4'(r), 16'(randBits(16)));
		for (int n = 0; n < 48; n++) begin
			opc        = 4'(randBits(3)) + 4'd1; // ADD up to MOV
			word       = regOp(opc, 4'(randBits(4)), 4'(randBits(4)), 4'(randBits(4)));
			instr      = word;
			instrValid = 1'b1;
			if (n > 0) begin
				// previous result is visible while this one is being decoded
				dbgAddr = prevRd;
				#1;
				checkEq($sformatf("step %0d r%0d", n - 1, prevRd), model[prevRd], dbgData);
				checkFlags();
			end
			applyModel(word);
			waitEdge();
			prevRd = word[11:8];
		end
		instrValid = 1'b0;
		readReg(prevRd);
		checkFlags();
		waitEdge();
		endTest();
	endtask

	task automatic addPair(input logic [31:0] a, input logic [31:0] b);
		logic [32:0] sum;
		sum = {1'b0, a} + {1'b0, b};
		loadReg(4'd0, a[15:0]);
		loadReg(4'd1, a[31:16]);
		loadReg(4'd2, b[15:0]);
		loadReg(4'd3, b[31:16]);
		issue(regOp(opcAdd, 4'd4, 4'd0, 4'd2));
		issue(regOp(opcAdc, 4'd5, 4'd1, 4'd3));
		readReg(4'd4);
		checkEq("sum low", sum[15:0], dbgData);
		readReg(4'd5);
		checkEq("sum high", sum[31:16], dbgData);
		checkFlags();
		checkEq("carry out", {15'b0, sum[32]}, {15'b0, carryFlag});
		waitEdge();
	endtask

	task automatic testMultiWord();
		startTest("multiWord");
		addPair(randBits(32), randBits(32));
		addPair(32'hffff_ffff, 32'h0000_0001); // wraps to zero with carry
		addPair(32'h0001_8000, 32'h0002_8000);
		loadReg(4'd6, 16'h0005);
		loadReg(4'd7, 16'h0009);
		issue(regOp(opcSub, 4'd8, 4'd6, 4'd7));
		readReg(4'd8);
		checkEq("borrow result", 16'hfffc, dbgData);
		checkFlags();
		checkEq("borrow", 16'd1, {15'b0, carryFlag});
		waitEdge();
		endTest();
	endtask

	task automatic testNoWrite();
		startTest("noWrite");
		// distinct nonzero contents make a stray write of zero or of r1 + r2 visible
		for (int r = 0; r < regCount; r++) loadReg(4'(r), {4'(r), 12'h5a3});
		instr      = regOp(opcAdd, 4'd9, 4'd1, 4'd2);
		instrValid = 1'b0; // writing opcodes, but never valid
		waitEdge();
		instr = immOp(opcLdi, 4'd10, 8'ha5);
		waitEdge();
		issue(regOp(opcNop, 4'd11, 4'd1, 4'd2));
		for (int c = 12; c < 16; c++) issue(regOp(4'(c), 4'(c - 11), 4'd1, 4'd2));
		readAll();
		endTest();
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		rstN       = 1'b0;
		instr      = '0;
		instrValid = 1'b0;
		dbgAddr    = '0;
		lfsrState  = 32'h6a98;
		checkCount = 0;
		errorCount = 0;
		modelCarry = 1'b0;
		modelZero  = 1'b0;
		testName   = "reset";
		for (int i = 0; i < regCount; i++) model[i] = '0;
		waitEdge();
		waitEdge();
		rstN = 1'b1;

		testReset();
		testStoreRetrieve();
		testManyStores();
		testRandomAlu();
		testMultiWord();
		testNoWrite();

		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
